//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// ############################################################
	// sizes
	// ############################################################
	localparam int ROM_WORDS   = 64;                  // instruction rom depth in words
	localparam int QUEUE_DEPTH = 4;                   // queue slots == credits after reset
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH); // read / write pointer width

	typedef logic [31:0]                    word_t;      // instruction or data word
	typedef logic [31:0]                    addr_t;      // byte address
	typedef logic [$clog2(ROM_WORDS)-1:0]   rom_index_t; // word index into the rom
	typedef logic [2:0]                     credit_t;    // 0 .. QUEUE_DEPTH
	typedef logic [QUEUE_PTR_W-1:0]         q_ptr_t;     // queue slot pointer

	localparam addr_t PC_STEP = 32'd4; // one word

	// ############################################################
	// fixed instruction words and decode fields
	// ############################################################
	localparam word_t INT_CALL_WORD = 32'h0340_d809; // jalr $i1, $i0
	localparam word_t NOP_WORD      = 32'h0000_0000; // sll $0, $0, 0

	localparam logic [5:0] OP_SPECIAL = 6'h00; // r-type, look at funct
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;

	// ############################################################
	// bundles
	// ############################################################
	typedef struct packed {
		addr_t pc;       // address the word was fetched from
		word_t inst;     // fetched or injected word
		logic  injected; // interrupt call or its slot nop
	} fetch_pkt_t;

	typedef struct packed {
		logic  valid;  // resolved branch / jump
		addr_t target; // new fetch address
	} redirect_t;

	typedef enum logic [1:0] {
		IDLE,      // normal fetch
		WAIT_SLOT, // delay slot still to be pushed
		CALL,      // inject handler call
		SLOT       // inject nop for its delay slot
	} int_state_e;

endpackage

`default_nettype wire

//--- source/inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
	input  wire fetch_pkg::addr_t addr,
	output fetch_pkg::word_t      data
);

	fetch_pkg::word_t      mem [fetch_pkg::ROM_WORDS]; // program image
	fetch_pkg::rom_index_t index;                      // word index, wraps past the end

	initial begin
		$readmemh("program.hex", mem);
	end

	// drop the byte offset, keep only the low index bits
	assign index = addr[2 +: $bits(fetch_pkg::rom_index_t)];

	assign data = mem[index]; // async read

endmodule

`default_nettype wire

//--- source/int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module int_ctrl (
	input  wire  clk,
	input  wire  rst,
	input  wire  irq,         // level request
	input  wire  eret,        // return from handler
	input  wire  int_taken,   // fetch committed to the call
	output logic int_req,
	output logic int_enabled
);

	logic enable; // global interrupt enable

	// ############################################################
	// enable bit
	// ############################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b1; // interrupts on out of reset
		end else if (int_taken) begin
			enable <= 1'b0; // auto-disable while handler runs
		end else if (eret) begin
			enable <= 1'b1; // handler done
		end
	end

	// masked request, so a taken interrupt cannot fire again
	// until the handler returns
	assign int_req     = irq && enable;
	assign int_enabled = enable;

endmodule

`default_nettype wire

//--- source/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        push,          // credit already spent by fetch
	input  wire fetch_pkg::fetch_pkt_t push_pkt,
	input  wire                        pop,           // decode side
	output fetch_pkg::fetch_pkt_t      head,
	output logic                       head_valid,
	output logic                       credit_return  // one pulse per real pop
);

	fetch_pkg::fetch_pkt_t mem [fetch_pkg::QUEUE_DEPTH]; // packet storage
	fetch_pkg::q_ptr_t     wr_ptr;                       // next free slot
	fetch_pkg::q_ptr_t     rd_ptr;                       // oldest packet
	fetch_pkg::credit_t    count;                        // packets held
	logic                  pop_ok;                       // pop of a valid head

	// ############################################################
	// status
	// ############################################################
	assign head_valid = (count != '0);
	assign pop_ok     = pop && head_valid; // pop on empty is ignored
	assign head       = mem[rd_ptr];

	// ############################################################
	// storage, no full check since credits bound the fill level
	// ############################################################
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_pkt;
		end
	end

	// ############################################################
	// pointers, count and credit pulse
	// ############################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + fetch_pkg::q_ptr_t'(1); // wraps, depth is a power of 2
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + fetch_pkg::q_ptr_t'(1);
			end
			count <= count
				+ fetch_pkg::credit_t'(push)
				- fetch_pkg::credit_t'(pop_ok); // both at once leaves it unchanged
			credit_return <= pop_ok; // slot freed, hand the credit back
		end
	end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire                        clk,
	input  wire                        rst,
	input  wire fetch_pkg::redirect_t  redirect,      // branch / jump from execute
	output fetch_pkg::addr_t           rom_addr,
	input  wire fetch_pkg::word_t      rom_data,
	input  wire                        credit_return, // one slot freed in the queue
	output logic                       push,
	output fetch_pkg::fetch_pkt_t      push_pkt,
	input  wire                        int_req,       // masked request
	output logic                       int_taken
);

	fetch_pkg::addr_t      pc;       // address being fetched
	fetch_pkg::credit_t    credits;  // free queue slots known here
	fetch_pkg::int_state_e state;
	fetch_pkg::int_state_e state_nx;
	logic                  last_ctl; // last pushed word was a branch / jump
	logic                  running;  // set one cycle after reset releases
	logic                  push_ok;  // push opportunity this cycle
	logic                  in_seq;   // injecting call or slot nop
	logic                  take;     // commit to the interrupt

	// control transfer decode, these all own a delay slot
	function automatic logic is_ctl(input fetch_pkg::word_t w);
		logic [5:0] op;
		logic [5:0] fn;
		op = w[31:26];
		fn = w[5:0];
		return (op == fetch_pkg::OP_BEQ) || (op == fetch_pkg::OP_BNE)
			|| (op == fetch_pkg::OP_J) || (op == fetch_pkg::OP_JAL)
			|| ((op == fetch_pkg::OP_SPECIAL)
				&& ((fn == fetch_pkg::FN_JR) || (fn == fetch_pkg::FN_JALR)));
	endfunction

	// ############################################################
	// push decision
	// ############################################################
	assign in_seq  = (state == fetch_pkg::CALL) || (state == fetch_pkg::SLOT);
	assign push_ok = running && !redirect.valid && (credits != '0); // redirect squashes

	// take uses the opportunity itself, the call goes out on the next one
	assign take      = push_ok && !in_seq && int_req && !last_ctl;
	assign int_taken = take;
	assign push      = push_ok && !take;
	assign rom_addr  = pc;

	// packet mux: rom word or one of the two injected words
	always_comb begin
		push_pkt.pc       = pc; // injected words keep the displaced pc
		push_pkt.injected = in_seq;
		case (state)
			fetch_pkg::CALL: push_pkt.inst = fetch_pkg::INT_CALL_WORD;
			fetch_pkg::SLOT: push_pkt.inst = fetch_pkg::NOP_WORD;
			default:         push_pkt.inst = rom_data;
		endcase
	end

	// ############################################################
	// interrupt injection fsm, advances only on push opportunities
	// ############################################################
	always_comb begin
		state_nx = state;
		if (push_ok) begin
			case (state)
				fetch_pkg::IDLE, fetch_pkg::WAIT_SLOT: begin
					if (!int_req) begin
						state_nx = fetch_pkg::IDLE; // request gone, plain fetch
					end else if (last_ctl) begin
						state_nx = fetch_pkg::WAIT_SLOT; // let the delay slot out first
					end else begin
						state_nx = fetch_pkg::CALL;
					end
				end
				fetch_pkg::CALL: state_nx = fetch_pkg::SLOT;
				default:         state_nx = fetch_pkg::IDLE; // slot nop done
			endcase
		end
	end

	// ############################################################
	// pc, credits and flags
	// ############################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= '0;
			credits  <= fetch_pkg::credit_t'(fetch_pkg::QUEUE_DEPTH); // queue empty
			state    <= fetch_pkg::IDLE;
			last_ctl <= 1'b0;
			running  <= 1'b0;
		end else begin
			running <= 1'b1;
			state   <= state_nx;
			credits <= credits
				- fetch_pkg::credit_t'(push)
				+ fetch_pkg::credit_t'(credit_return); // returned credit usable next cycle
			if (redirect.valid) begin
				pc <= redirect.target; // also during call / slot, sequence continues
			end else if (push && !in_seq) begin
				pc <= pc + fetch_pkg::PC_STEP; // pc holds under injection
			end
			if (push) begin
				last_ctl <= is_ctl(push_pkt.inst); // injected jalr counts too
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  wire                       clk,
	input  wire                       rst,
	input  wire fetch_pkg::redirect_t redirect,
	input  wire                       irq,
	input  wire                       eret,
	input  wire                       pop,
	output fetch_pkg::fetch_pkt_t     head,
	output logic                      head_valid,
	output logic                      int_enabled
);

	fetch_pkg::addr_t      rom_addr;
	fetch_pkg::word_t      rom_data;
	logic                  push;          // fetch -> queue
	fetch_pkg::fetch_pkt_t push_pkt;
	logic                  credit_return; // queue -> fetch
	logic                  int_req;       // controller -> fetch
	logic                  int_taken;     // fetch -> controller

	// ############################################################
	// front end
	// ############################################################
	inst_rom i_inst_rom (
		.addr (rom_addr),
		.data (rom_data)
	);

	int_ctrl i_int_ctrl (
		.clk         (clk),
		.rst         (rst),
		.irq         (irq),
		.eret        (eret),
		.int_taken   (int_taken),
		.int_req     (int_req),
		.int_enabled (int_enabled)
	);

	fetch_stage i_fetch_stage (
		.clk           (clk),
		.rst           (rst),
		.redirect      (redirect),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.credit_return (credit_return),
		.push          (push),
		.push_pkt      (push_pkt),
		.int_req       (int_req),
		.int_taken     (int_taken)
	);

	fetch_queue i_fetch_queue (
		.clk           (clk),
		.rst           (rst),
		.push          (push),
		.push_pkt      (push_pkt),
		.pop           (pop),
		.head          (head),
		.head_valid    (head_valid),
		.credit_return (credit_return)
	);

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

endmodule

`default_nettype wire

//--- bench/fetch_props.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_props (
	input wire                     clk,
	input wire                     rst,
	input wire fetch_pkg::credit_t level,      // credits in fetch, fill level in the queue
	input wire fetch_pkg::credit_t room,       // free slots seen by the pushed side
	input wire                     push,
	input wire                     int_taken,
	input wire                     head_valid
);

	// ############################################################
	// credit accounting
	// ############################################################
	credit_bound: assert property (@(posedge clk) disable iff (rst)
		level <= fetch_pkg::credit_t'(fetch_pkg::QUEUE_DEPTH))
		else $error("credit count or queue fill above queue depth");

	push_needs_credit: assert property (@(posedge clk) disable iff (rst)
		push |-> (room != '0))
		else $error("push with no credit left");

	// ############################################################
	// reset and interrupt take
	// ############################################################
	reset_quiet: assert property (@(posedge clk)
		rst |=> (!push && !head_valid))
		else $error("push or head_valid high right after reset");

	single_take: assert property (@(posedge clk) disable iff (rst)
		int_taken |-> (!$past(int_taken) && !$past(int_taken, 2)))
		else $error("int_taken high twice within two cycles");

endmodule

bind fetch_stage fetch_props i_stage_props (
	.clk        (clk),
	.rst        (rst),
	.level      (credits),
	.room       (credits),
	.push       (1'b0),    // push is seen where it lands, in the queue
	.int_taken  (int_taken),
	.head_valid (1'b0)     // no queue status in the fetch stage
);

bind fetch_queue fetch_props i_queue_props (
	.clk        (clk),
	.rst        (rst),
	.level      (count),
	.room       (fetch_pkg::credit_t'(fetch_pkg::QUEUE_DEPTH) - count), // empty slots
	.push       (push),
	.int_taken  (1'b0),
	.head_valid (head_valid)
);

`default_nettype wire

//--- bench/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

	logic                  clk;
	logic                  rst;
	fetch_pkg::redirect_t  redirect;
	logic                  irq;
	logic                  eret;
	logic                  pop = 1'b0;
	fetch_pkg::fetch_pkt_t head;
	logic                  head_valid;
	logic                  int_enabled;

	fetch_pkg::word_t rom_img [fetch_pkg::ROM_WORDS];  // own copy of the program
	fetch_pkg::addr_t branch_at [4] = '{32'h0c, 32'h1c, 32'h28, 32'h64}; // words with a slot
	int               pop_mode = 0;                    // 0 off, 1 always, 2 random
	fetch_pkg::addr_t exp_pc = '0;                     // next sequential pc
	fetch_pkg::word_t last_word = '0;                  // word of the previous popped packet
	logic             in_pair = 1'b0;                  // call seen, slot nop due
	int               pairs = 0;                       // injected pairs seen
	int               popped = 0;
	fetch_pkg::addr_t redir_target;
	int               redirects_sent = 0;
	int               redirects_done = 0;
	int               seq_after = 0;                   // old packets popped after a redirect

	tb_clock i_tb_clock (.clk(clk));

	fetch_top i_fetch_top (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.irq         (irq),
		.eret        (eret),
		.pop         (pop),
		.head        (head),
		.head_valid  (head_valid),
		.int_enabled (int_enabled)
	);

	// ############################################################
	// reference model
	// ############################################################
	function automatic fetch_pkg::word_t rom_word(input fetch_pkg::addr_t pc);
		return rom_img[pc[2 +: $clog2(fetch_pkg::ROM_WORDS)]]; // wraps past the end
	endfunction

	function automatic logic has_delay_slot(input fetch_pkg::word_t w);
		case (w[31:26])
			6'h02, 6'h03, 6'h04, 6'h05: return 1'b1;     // j, jal, beq, bne
			6'h00:                      return w[5:1] == 5'b00100; // jr, jalr
			default:                    return 1'b0;
		endcase
	endfunction

	task automatic end_in_failure(input string line);
		$display("%s", line);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			end_in_failure($sformatf("error at %0d ns: %s, got %08h, expected %08h",
				$time, what, actual, expected));
		end
	endtask

	task automatic wait_popped(input int target);
		int n = 0;
		while (popped < target) begin
			@(negedge clk);
			n++;
			if (n > 2000) end_in_failure("timeout: decode side stopped receiving packets");
		end
	endtask

	task automatic wait_pairs(input int target);
		int n = 0;
		while (pairs < target) begin
			@(negedge clk);
			n++;
			if (n > 300) end_in_failure("timeout: interrupt pair never reached decode");
		end
	endtask

	task automatic start_redirect(input fetch_pkg::addr_t t);
		redir_target    = t;
		redirect.target = t;
		redirect.valid  = 1'b1;
		redirects_sent++;
	endtask

	// decode side pop pattern
	always @(negedge clk) begin
		case (pop_mode)
			0:       pop = 1'b0;
			1:       pop = 1'b1;
			default: pop = ($urandom_range(0, 3) != 0); // roughly 3 of 4 cycles
		endcase
	end

	// ############################################################
	// compare every popped packet with the expected stream
	// ############################################################
	always @(posedge clk) begin
		if (!rst && pop && head_valid) begin
			if (redirects_sent != redirects_done) begin
				if (head.pc == redir_target) begin
					exp_pc         = redir_target; // stream switches here, once
					redirects_done = redirects_sent;
					seq_after      = 0;
				end else begin
					seq_after++;
					check_equal(32'(seq_after <= fetch_pkg::QUEUE_DEPTH), 1,
						"old packets after redirect exceed queue depth");
				end
			end
			if (in_pair) begin
				check_equal(32'(head.injected), 1, "slot nop injected flag");
				check_equal(head.inst, fetch_pkg::NOP_WORD, "slot nop word");
				check_equal(head.pc, exp_pc, "slot nop pc");
				in_pair = 1'b0;
				pairs++;
			end else if (head.injected) begin
				check_equal(head.inst, fetch_pkg::INT_CALL_WORD, "interrupt call word");
				check_equal(head.pc, exp_pc, "interrupt call pc");
				check_equal(32'(has_delay_slot(last_word)), 0, "call placed in a delay slot");
				in_pair = 1'b1;
			end else begin
				check_equal(head.pc, exp_pc, "sequential pc");
				check_equal(head.inst, rom_word(exp_pc), "fetched word");
				exp_pc = exp_pc + 32'd4;
			end
			last_word = head.inst;
			popped++;
		end
	end

	// ############################################################
	// stimulus
	// ############################################################
	initial begin
		fetch_pkg::addr_t target;
		int               n;
		void'($urandom(32'h6352_75b5));
		$readmemh("program.hex", rom_img);
		rst      = 1'b1;
		redirect = '0;
		irq      = 1'b0;
		eret     = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		pop_mode = 1; // straight fetch
		wait_popped(40);
		pop_mode = 2; // back-pressure
		wait_popped(popped + 150);

		// redirect held until the queue has drained
		pop_mode = 1;
		target = ($urandom() & 32'h0fff_fffc) | 32'h4000_0000;
		start_redirect(target);
		n = 0;
		while (head_valid) begin
			@(negedge clk);
			n++;
			if (n > 20) end_in_failure("timeout: queue never drained during redirect");
		end
		repeat (3) begin
			@(negedge clk);
			check_equal(32'(head_valid), 0, "head_valid with every packet popped");
		end
		redirect.valid = 1'b0;
		pop_mode = 2;
		wait_popped(popped + 60);
		check_equal(32'(redirects_done), 32'(redirects_sent), "first redirect target seen");

		// single cycle redirect under random pops
		start_redirect(($urandom() & 32'h0fff_fffc) | 32'h6000_0000);
		@(negedge clk);
		redirect.valid = 1'b0;
		wait_popped(popped + 60);
		check_equal(32'(redirects_done), 32'(redirects_sent), "second redirect target seen");
		check_equal(32'(pairs), 0, "injection without irq");

		// interrupt, then masking while irq stays high
		irq = 1'b1;
		n = 0;
		while (int_enabled) begin
			@(negedge clk);
			n++;
			if (n > 100) end_in_failure("timeout: int_enabled never fell after irq");
		end
		wait_pairs(1);
		repeat (60) @(negedge clk);
		check_equal(32'(pairs), 1, "injection while interrupts disabled");
		eret = 1'b1;
		@(negedge clk);
		check_equal(32'(int_enabled), 1, "int_enabled after eret");
		eret = 1'b0;
		wait_pairs(2);
		irq = 1'b0;
		repeat (40) @(negedge clk);
		check_equal(32'(pairs), 2, "pairs after one eret");
		check_equal(32'(int_enabled), 0, "int_enabled after second take");

		// irq raised around branches, call must never land in a slot
		pop_mode = 1;
		for (int t = 0; t < 12; t++) begin
			eret = 1'b1;
			@(negedge clk);
			eret = 1'b0;
			start_redirect(32'h8000_0000 + 32'h1000 * t + branch_at[t % 4] - 32'd8);
			@(negedge clk);
			redirect.valid = 1'b0;
			repeat (t % 6) @(negedge clk); // sweep irq against the branch push
			irq = 1'b1;
			wait_pairs(3 + t);
			irq = 1'b0;
		end
		check_equal(32'(pairs), 14, "total injected pairs");

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- program.hex
// instruction rom image, 64 words of 32-bit hex, four words per line
// first column of data line n holds word 4*n, byte address 16*n
3c081000 25080001 01095021 10850003
25290001 8d0a0004 ad0a0008 14a6fffb
00000000 35290010 08000010 25080002
01095021 0c000020 25290003 3c090002
8d0b0010 03e00008 25080004 ad0b000c
0040f809 00000000 25290005 01095023
10000002 1500fffe 25080006 35290020
8d0c0014 25290007 11090004 00000000
3c0a0004 25080008 ad0c0018 0800001c
25290009 01095021 1520fff8 2508000a
8d0d001c 3529ffff 0c00003c 00000000
2508000b ad0d0020 03200008 2529000c
01095021 11400010 2508000d 8d0e0024
00000000 0120f809 2529000e 3c0b0008
2508000f 1560ffe0 ad0e0028 01095021
25290010 08000000 00000000 2508ffff

//--- verilog.f
source/fetch_pkg.sv
source/inst_rom.sv
source/int_ctrl.sv
source/fetch_queue.sv
source/fetch_stage.sv
source/fetch_top.sv
bench/tb_clock.sv
bench/fetch_props.sv
bench/tb_fetch.sv

//--- run.sh
#!/bin/sh
# build the fetch front end testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_fetch -f verilog.f -o tb_fetch
./obj_dir/tb_fetch
